/* verification/nes_bus_golden.txt */
# command  address  data  expected (hex); joypad reads leave the pad bits 0
# cpu_read: data drives ppu_dout/apu_status; cpu_write: expected is the strobe; chr: data is the program address
cpu_read   0012    00    48
cpu_read   4016    00    44
cpu_read   4017    00    40
cpu_read   80C7    00    9D
cpu_read   4020    00    9D
cpu_read   4000    00    9D
cpu_read   4015    3C    3C
cpu_read   40FF    00    3C
cpu_read   2002    A5    A5
cpu_read   3FFF    81    81
cpu_read   4016    00    84
cpu_read   4017    00    80
cpu_write  4016    01    01
cpu_write  4016    00    00
cpu_write  0300    77    00
chr        012345  8123  79
cpu_write  4014    03    00
dmc        C1F0    10    AA
cpu_write  4014    05    00
pal        0000    00    00
pal        0000    01    00
cpu_read   0044    00    1E

/* flist.f */
source/nes_bus_pkg.sv
source/clock_enables.sv
source/dma_controller.sv
source/cpu_bus_decode.sv
source/memory_multiplex.sv
source/nes_bus_top.sv
verification/tb_clock.sv
verification/nes_bus_tb.sv

/* Makefile */
TOOL    = verilator
FLAGS   = --binary --timing --assert -j 0
TOP     = nes_bus_tb
RTL_TOP = nes_bus_top
FLIST   = flist.f
BUILD   = obj_dir
LOG     = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG) || ! grep -q "NO ERRORS" $(LOG); then \
		echo "Simulation failed"; exit 1; fi

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD) $(LOG)

/* verification/nes_bus_tb.sv */
// Testbench for the bus core; replays the golden step file against the DUT and checks results
`timescale 1ns/100ps

module nes_bus_tb;
	import nes_bus_pkg::*;

	logic       clk;
	logic       reset;
	logic       reset_req;
	logic [1:0] sys_type;
	cpu_bus_t   cpu_in;
	cpu_bus_t   bus_out;
	logic       pause_cpu;
	logic       dmc_req;
	logic       dmc_ack;
	cpu_addr_t  dmc_addr;
	byte_t      ppu_dout;
	byte_t      apu_status;
	byte_t      mem_din_cpu;
	byte_t      cpu_din;
	logic [3:0] joypad_data;
	logic       mic;
	mem_req_t   chr_req;
	mem_req_t   mem;
	logic       mem_read_ppu;
	joypad_t    joypad;
	clk_en_t    ce;

	int          errors = 0;
	int          checks = 0;
	int          seed = 73;
	int          clk_count = 0;
	int          clk_limit = 0;  // 0 until the step file is read
	logic [31:0] rnd;            // Last random draw, low nibble is the pad data
	byte_t       ppu_v;          // Value put on ppu_dout and apu_status
	logic        dmc_req_v;
	cpu_addr_t   dmc_addr_v;
	logic        dmc_pending;
	byte_t       dmc_n;          // Sprite index at which the DMC asks
	byte_t       dmc_exp;
	logic [127:0] cmd_q[$];
	logic [31:0]  a_q[$];
	logic [31:0]  d_q[$];
	logic [31:0]  e_q[$];

	tb_clock i_tb_clock (
		.reset_req (reset_req),
		.clk       (clk),
		.reset     (reset)
	);

	nes_bus_top i_nes_bus_top (
		.clk          (clk),
		.reset        (reset),
		.sys_type     (sys_type),
		.cpu_in       (cpu_in),
		.pause_cpu    (pause_cpu),
		.dmc_req      (dmc_req),
		.dmc_addr     (dmc_addr),
		.dmc_ack      (dmc_ack),
		.ppu_dout     (ppu_dout),
		.apu_status   (apu_status),
		.joypad_data  (joypad_data),
		.mic          (mic),
		.chr_req      (chr_req),
		.mem_din_cpu  (mem_din_cpu),
		.cpu_din      (cpu_din),
		.bus_out      (bus_out),
		.joypad       (joypad),
		.mem          (mem),
		.mem_read_ppu (mem_read_ppu),
		.ce           (ce)
	);

	// Memory model, data is the address low byte scrambled
	always @(posedge clk) mem_din_cpu <= bus_out.addr[7:0] ^ 8'h5A;

	always @(posedge clk) begin
		clk_count = clk_count + 1;
		if (clk_limit > 0 && clk_count > clk_limit) begin
			$display("Timeout after %0d clocks, the test did not finish", clk_count);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	task automatic check_byte(input string what, input byte_t got, input byte_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	// Data field only matters on writes
	task automatic check_bus(input string what, input cpu_bus_t got, input cpu_bus_t exp,
			input logic with_data);
		checks++;
		if (with_data ? got !== exp
				: {got.addr, got.read, got.write} !== {exp.addr, exp.read, exp.write}) begin
			errors++;
			$display("ERR %0t: %s got %h/%h r%b w%b expected %h/%h r%b w%b", $time, what,
				got.addr, got.data, got.read, got.write, exp.addr, exp.data, exp.read, exp.write);
		end
	endtask

	task automatic check_mem(input string what, input mem_req_t got, input mem_req_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_pad(input string what, input joypad_t got, input joypad_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("ERR %0t: %s got %0d clocks expected %0d", $time, what, got, exp);
		end
	endtask

	// Leaves the TB on the last clock of a CPU cycle, outputs settled
	task automatic end_cycle();
		@(negedge clk);
		while (!ce.cpu_ce) @(negedge clk);
	endtask

	task automatic wait_ppu();
		@(negedge clk);
		while (!ce.ppu_ce) @(negedge clk);
	endtask

	// One CPU cycle, inputs change on the cpu_ce edge
	task automatic run_cycle(input cpu_bus_t b);
		@(posedge clk);
		rnd = $random(seed);
		cpu_in      <= b;
		joypad_data <= rnd[3:0];
		ppu_dout    <= ppu_v;
		apu_status  <= ppu_v;
		dmc_req     <= dmc_req_v;
		dmc_addr    <= dmc_addr_v;
		end_cycle();
	endtask

	task automatic wait_release();
		int count;
		count = 0;
		do @(negedge clk); while (reset);
		check_bit("pause_cpu after reset", pause_cpu, 1'b0);
		check_bit("dmc_ack after reset", dmc_ack, 1'b0);
		check_pad("Joypad after reset", joypad, 3'b000);
		check_bit("mem.read after reset", mem.read, 1'b0);
		check_bit("mem.write after reset", mem.write, 1'b0);
		while (!ce.cpu_ce) begin
			@(negedge clk);
			count++;
		end
		check_count("First CPU period", count, DIV_CPU_DEFAULT - 1);
	endtask

	task automatic apply_reset(input logic [1:0] sys);
		@(posedge clk);
		sys_type  <= sys;  // Taken by the DUT only under reset
		cpu_in    <= '0;
		chr_req   <= '0;
		reset_req <= 1'b1;
		@(posedge clk);
		reset_req <= 1'b0;
		wait_release();
	endtask

	// Every fifth PAL period carries one extra clock and moves the slots one tick late
	task automatic measure_periods(input logic pal);
		int   i;
		int   count;
		int   tick;       // PPU ticks seen since the last cpu_ce
		logic stretched;
		for (i = 0; i < 10; i++) begin
			count     = 0;
			tick      = 0;
			stretched = pal && i % 5 == 3;
			do begin
				@(negedge clk);
				count++;
				check_bit("cart_pre slot", ce.cart_pre, tick == (stretched ? 1 : 0));
				check_bit("ppu_io slot", ce.ppu_io, tick == (stretched ? 2 : 1));
				if (ce.ppu_ce)
					tick++;
			end while (!ce.cpu_ce);
			check_count("CPU period", count, stretched ? 13 : 12);
		end
		while (!ce.ppu_ce) @(negedge clk);
		for (i = 0; i < 3; i++) begin
			count = 0;
			do begin
				@(negedge clk);
				count++;
			end while (!ce.ppu_ce);
			check_count("PPU period", count, DIV_PPU_DEFAULT);
		end
		end_cycle();
	endtask

	function automatic byte_t pad_bits(input cpu_addr_t a, input logic [3:0] jd);
		if (a == JOY1_ADDR)
			return {7'b0, jd[0]};
		if (a == JOY2_ADDR)
			return {3'b0, jd[3:2], 2'b00, jd[1]};
		return 8'h00;
	endfunction

	task automatic do_read(input cpu_addr_t a, input byte_t d, input byte_t e);
		cpu_bus_t b;
		b = '{addr: a, data: 8'h00, read: 1'b1, write: 1'b0};
		ppu_v = d;
		run_cycle(b);
		check_bus("CPU read on bus", bus_out, b, 1'b1);
		check_byte("Read data", cpu_din, e | pad_bits(a, rnd[3:0]));  // File leaves pad bits 0
		check_pad("Joypad on read", joypad, {1'b0, a == JOY2_ADDR, a == JOY1_ADDR});
	endtask

	task automatic do_chr(input mem_addr_t ca, input cpu_addr_t pa, input byte_t e);
		@(posedge clk);
		cpu_in  <= '{addr: pa, data: 8'h00, read: 1'b1, write: 1'b0};
		chr_req <= '{addr: ca, data: 8'h00, read: 1'b1, write: 1'b0};
		wait_ppu();
		check_mem("PPU access first", mem, '{addr: ca, data: 8'h00, read: 1'b1, write: 1'b0});
		check_bit("mem_read_ppu", mem_read_ppu, 1'b1);
		@(posedge clk);
		chr_req <= '0;
		wait_ppu();
		check_mem("Deferred program read", mem,
			'{addr: mem_addr_t'(pa), data: 8'h00, read: 1'b1, write: 1'b0});
		check_bit("mem_read_ppu", mem_read_ppu, 1'b0);
		end_cycle();
		check_byte("Program read data", cpu_din, e);
	endtask

	// Sprite DMA after the $4014 write, with an optional DMC steal
	task automatic run_sprite(input byte_t page);
		int       n;
		logic     wr;
		logic     started;
		logic     idle_ok;
		logic     done;
		cpu_bus_t idle;
		cpu_bus_t exp;
		n       = 0;
		wr      = 1'b0;
		started = 1'b0;
		idle_ok = 1'b0;
		done    = 1'b0;
		idle    = '{addr: 16'h8000, data: 8'h00, read: 1'b1, write: 1'b0};
		while (!done) begin
			run_cycle(idle);
			if (dmc_ack) begin
				check_bit("DMC fetch on odd cycle", ce.odd_cycle, 1'b0);
				check_bus("DMC fetch", bus_out, '{addr: dmc_addr_v, data: 8'h00, read: 1'b1,
					write: 1'b0}, 1'b0);
				check_byte("DMC data", cpu_din, dmc_exp);
				dmc_req_v   = 1'b0;  // Dropped on the edge that ends the fetch
				dmc_pending = 1'b0;
				idle_ok     = 1'b1;
			end else if (bus_out == idle && (!started || idle_ok)) begin
				idle_ok = 1'b0;
			end else begin
				started = 1'b1;
				if (!wr)
					exp = '{addr: {page, n[7:0]}, data: 8'h00, read: 1'b1, write: 1'b0};
				else
					exp = '{addr: OAM_DATA_ADDR, data: n[7:0] ^ 8'h5A, read: 1'b0, write: 1'b1};
				check_bus(wr ? "Sprite write" : "Sprite read", bus_out, exp, wr);
				check_bit("pause_cpu during sprite DMA", pause_cpu, 1'b1);
				if (!wr && dmc_pending && n[7:0] == dmc_n)
					dmc_req_v = 1'b1;
				if (wr) begin
					done = n == 255;
					n++;
				end
				wr = !wr;
			end
		end
		run_cycle(idle);
		check_bit("pause_cpu after sprite DMA", pause_cpu, 1'b0);
		check_bus("CPU bus back after DMA", bus_out, idle, 1'b1);
		if (dmc_pending) begin
			errors++;
			$display("The DMC fetch never happened during the sprite DMA at %0t", $time);
		end
	endtask

	task automatic run_steps();
		int i;
		for (i = 0; i < cmd_q.size(); i++) begin
			if (cmd_q[i] == "cpu_read")
				do_read(a_q[i][15:0], d_q[i][7:0], e_q[i][7:0]);
			else if (cmd_q[i] == "cpu_write") begin
				run_cycle('{addr: a_q[i][15:0], data: d_q[i][7:0], read: 1'b0, write: 1'b1});
				check_bus("CPU write on bus", bus_out,
					'{addr: a_q[i][15:0], data: d_q[i][7:0], read: 1'b0, write: 1'b1}, 1'b1);
				check_pad("Joypad on write", joypad, {e_q[i][0], 2'b00});
				if (a_q[i][15:0] == OAM_DMA_ADDR)
					run_sprite(d_q[i][7:0]);
			end else if (cmd_q[i] == "dmc") begin
				dmc_addr_v  = a_q[i][15:0];  // Armed for the next sprite DMA
				dmc_n       = d_q[i][7:0];
				dmc_exp     = e_q[i][7:0];
				dmc_pending = 1'b1;
			end else if (cmd_q[i] == "chr")
				do_chr(a_q[i][21:0], d_q[i][15:0], e_q[i][7:0]);
			else if (cmd_q[i] == "pal") begin
				apply_reset(d_q[i][1:0]);
				measure_periods(d_q[i][0]);
			end else begin
				errors++;
				$display("Unknown command on golden step %0d", i);
			end
		end
	endtask

	initial begin
		int          fd;
		int          dma_steps;
		string       line;
		logic [127:0] cmd;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] e;
		sys_type    = 2'b00;
		reset_req   = 1'b0;
		cpu_in      = '0;
		dmc_req     = 1'b0;
		dmc_addr    = '0;
		ppu_dout    = '0;
		apu_status  = '0;
		mem_din_cpu = '0;
		joypad_data = '0;
		mic         = 1'b1;
		chr_req     = '0;
		ppu_v       = '0;
		dmc_req_v   = 1'b0;
		dmc_addr_v  = '0;
		dmc_pending = 1'b0;
		dmc_n       = '0;
		dmc_exp     = '0;
		dma_steps   = 0;
		fd = $fopen("verification/nes_bus_golden.txt", "r");
		if (fd == 0) begin
			$display("Could not open verification/nes_bus_golden.txt");
			$display("ERRORS FOUND");
			$finish;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 2 && line[0] != "#" &&
						$sscanf(line, "%s %h %h %h", cmd, a, d, e) == 4) begin
					cmd_q.push_back(cmd);
					a_q.push_back(a);
					d_q.push_back(d);
					e_q.push_back(e);
					if (cmd == "dmc" || (cmd == "cpu_write" && a[15:0] == OAM_DMA_ADDR))
						dma_steps++;
				end
			end
			$fclose(fd);
			clk_limit = (2000 + 600 * dma_steps) * (DIV_CPU_DEFAULT + 1);
			wait_release();
			run_steps();
			$display("Checks: %0d, errors: %0d", checks, errors);
			if (errors == 0)
				$display("NO ERRORS");
			else
				$display("ERRORS FOUND");
			$finish;
		end
	end

endmodule

/* verification/tb_clock.sv */
// Testbench clock and reset source; 10 ns clock, reset held 4 cycles at start and on request
`timescale 1ns/100ps

module tb_clock (
	input  logic reset_req,  // One-clock pulse asks for another reset
	output logic clk,
	output logic reset
);
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		forever begin
			@(posedge clk);
			if (reset_req) begin
				reset <= 1'b1;
				repeat (4) @(posedge clk);
				reset <= 1'b0;
			end
		end
	end

endmodule

/* source/nes_bus_top.sv */
// Console bus and clocking core; external CPU, APU and PPU cores connect through these ports
`timescale 1ns/100ps

module nes_bus_top #(
	parameter int div_cpu_n = nes_bus_pkg::DIV_CPU_DEFAULT,
	parameter int div_ppu_n = nes_bus_pkg::DIV_PPU_DEFAULT
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic [1:0]             sys_type,
	input  nes_bus_pkg::cpu_bus_t  cpu_in,       // From the processor
	output logic                   pause_cpu,    // Ready low
	input  logic                   dmc_req,
	input  nes_bus_pkg::cpu_addr_t dmc_addr,
	output logic                   dmc_ack,
	input  nes_bus_pkg::byte_t     ppu_dout,
	input  nes_bus_pkg::byte_t     apu_status,
	input  logic [3:0]             joypad_data,
	input  logic                   mic,
	input  nes_bus_pkg::mem_req_t  chr_req,      // From the picture unit
	input  nes_bus_pkg::byte_t     mem_din_cpu,
	output nes_bus_pkg::byte_t     cpu_din,
	output nes_bus_pkg::cpu_bus_t  bus_out,      // To the register devices
	output nes_bus_pkg::joypad_t   joypad,
	output nes_bus_pkg::mem_req_t  mem,
	output logic                   mem_read_ppu,
	output nes_bus_pkg::clk_en_t   ce            // Shared with the external cores
);
	import nes_bus_pkg::*;

	cpu_bus_t dma_bus;
	logic     dma_active;
	mem_req_t prg_req;

	clock_enables #(
		.div_cpu_n (div_cpu_n),
		.div_ppu_n (div_ppu_n)
	) i_clock_enables (
		.clk      (clk),
		.reset    (reset),
		.sys_type (sys_type),
		.ce       (ce)
	);

	dma_controller i_dma_controller (
		.clk        (clk),
		.reset      (reset),
		.ce         (ce),
		.cpu_bus    (bus_out),
		.cpu_read   (cpu_in.read),
		.dmc_req    (dmc_req),
		.dmc_addr   (dmc_addr),
		.ram_data   (cpu_din),     // DMA reads through the CPU data mux
		.dma_bus    (dma_bus),
		.dma_active (dma_active),
		.dmc_ack    (dmc_ack),
		.pause_cpu  (pause_cpu)
	);

	cpu_bus_decode i_cpu_bus_decode (
		.clk         (clk),
		.reset       (reset),
		.ce          (ce),
		.cpu_in      (cpu_in),
		.dma_bus     (dma_bus),
		.dma_active  (dma_active),
		.ppu_dout    (ppu_dout),
		.apu_status  (apu_status),
		.mem_din_cpu (mem_din_cpu),
		.joypad_data (joypad_data),
		.mic         (mic),
		.bus_out     (bus_out),
		.cpu_din     (cpu_din),
		.joypad      (joypad),
		.prg_req     (prg_req)
	);

	memory_multiplex i_memory_multiplex (
		.clk          (clk),
		.reset        (reset),
		.ce           (ce),
		.prg_req      (prg_req),
		.chr_req      (chr_req),
		.mem          (mem),
		.mem_read_ppu (mem_read_ppu)
	);

endmodule

/* source/memory_multiplex.sv */
// Shares one memory between PPU accesses and program accesses, PPU first
`timescale 1ns/100ps

module memory_multiplex (
	input  logic                  clk,
	input  logic                  reset,
	input  nes_bus_pkg::clk_en_t  ce,
	input  nes_bus_pkg::mem_req_t prg_req,
	input  nes_bus_pkg::mem_req_t chr_req,
	output nes_bus_pkg::mem_req_t mem,
	output logic                  mem_read_ppu
);
	logic saved_read;   // Program read pushed back by the PPU
	logic saved_write;
	logic chr_active;

	assign chr_active = chr_req.read || chr_req.write;

	// PPU is served in the clock it asks, program gets the free ticks
	assign mem.addr     = chr_active ? chr_req.addr : prg_req.addr;
	assign mem.data     = chr_req.write ? chr_req.data : prg_req.data;
	assign mem.read     = chr_active ? chr_req.read : (prg_req.read || saved_read);
	assign mem.write    = chr_active ? chr_req.write : (prg_req.write || saved_write);
	assign mem_read_ppu = chr_req.read;

	always_ff @(posedge clk) begin
		if (reset) begin
			saved_read  <= 1'b0;
			saved_write <= 1'b0;
		end else if (ce.ppu_ce) begin
			if (chr_active) begin
				saved_read  <= prg_req.read || saved_read;   // Collided, keep for later
				saved_write <= prg_req.write || saved_write;
			end else begin
				saved_read  <= 1'b0;  // Served in this tick
				saved_write <= 1'b0;
			end
		end
	end

	chr_single_op: assert property (@(posedge clk) disable iff (reset)
		!(chr_req.read && chr_req.write))
		else $error("PPU requested read and write together");
	mem_single_op: assert property (@(posedge clk) disable iff (reset)
		!(mem.read && mem.write))
		else $error("Memory read and write presented together");

endmodule

/* source/cpu_bus_decode.sv */
// CPU/DMA bus merge, address decode, joypad strobes and CPU read-data mux with open bus
`timescale 1ns/100ps

module cpu_bus_decode (
	input  logic                  clk,
	input  logic                  reset,
	input  nes_bus_pkg::clk_en_t  ce,
	input  nes_bus_pkg::cpu_bus_t cpu_in,
	input  nes_bus_pkg::cpu_bus_t dma_bus,
	input  logic                  dma_active,
	input  nes_bus_pkg::byte_t    ppu_dout,
	input  nes_bus_pkg::byte_t    apu_status,
	input  nes_bus_pkg::byte_t    mem_din_cpu,
	input  logic [3:0]            joypad_data,  // Pads 1 and 2, plus power pad bits
	input  logic                  mic,
	output nes_bus_pkg::cpu_bus_t bus_out,
	output nes_bus_pkg::byte_t    cpu_din,
	output nes_bus_pkg::joypad_t  joypad,
	output nes_bus_pkg::mem_req_t prg_req
);
	import nes_bus_pkg::*;

	logic  apu_cs;
	logic  ppu_cs;
	logic  open_cs;
	logic  joy1_cs;
	logic  joy2_cs;
	logic  prg_cs;
	byte_t open_bus;   // Last value seen on the data bus
	byte_t read_data;

	// DMA owns the bus while it is active
	assign bus_out = dma_active ? dma_bus : cpu_in;

	assign apu_cs  = bus_out.addr >= APU_LO && bus_out.addr < APU_HI;
	assign ppu_cs  = bus_out.addr >= PPU_LO && bus_out.addr < PPU_HI;
	assign open_cs = bus_out.addr >= OPEN_LO && bus_out.addr < OPEN_HI;
	assign joy1_cs = bus_out.addr == JOY1_ADDR;
	assign joy2_cs = bus_out.addr == JOY2_ADDR;
	assign prg_cs  = !apu_cs && !ppu_cs;  // Cartridge space, RAM included

	always_comb begin
		if (reset)
			read_data = '0;
		else if (joy1_cs)
			read_data = {open_bus[7:5], 2'b00, mic, 1'b0, joypad_data[0]};
		else if (joy2_cs)
			read_data = {open_bus[7:5], joypad_data[3:2], 2'b00, joypad_data[1]};
		else if (bus_out.addr == APU_STATUS_ADDR)
			read_data = apu_status;
		else if (apu_cs || open_cs)
			read_data = open_bus;   // Write-only APU registers and unmapped space
		else if (ppu_cs)
			read_data = ppu_dout;
		else
			read_data = mem_din_cpu;
	end

	assign cpu_din = read_data;

	always_ff @(posedge clk) begin
		open_bus <= read_data;  // Bus capacitance keeps the last byte
	end

	// Strobe is bit 0 of a $4016 write, clocks come from pad reads
	assign joypad.strobe = joy1_cs && bus_out.write && bus_out.data[0];
	assign joypad.clock  = {joy2_cs && bus_out.read, joy1_cs && bus_out.read};

	// No mapper, program addresses are zero-extended
	assign prg_req.addr  = {{(MEM_ADDR_W - CPU_ADDR_W){1'b0}}, bus_out.addr};
	assign prg_req.data  = bus_out.data;
	assign prg_req.read  = bus_out.read && ce.cart_pre && prg_cs;
	assign prg_req.write = bus_out.write && ce.cart_pre && prg_cs;

endmodule

/* source/dma_controller.sv */
// Sprite and DMC DMA engine; takes the CPU bus and pauses the processor while it runs
`timescale 1ns/100ps

module dma_controller (
	input  logic                   clk,
	input  logic                   reset,
	input  nes_bus_pkg::clk_en_t   ce,
	input  nes_bus_pkg::cpu_bus_t  cpu_bus,   // Merged bus, watched for the $4014 write
	input  logic                   cpu_read,  // CPU itself is in a read cycle
	input  logic                   dmc_req,
	input  nes_bus_pkg::cpu_addr_t dmc_addr,
	input  nes_bus_pkg::byte_t     ram_data,
	output nes_bus_pkg::cpu_bus_t  dma_bus,
	output logic                   dma_active,
	output logic                   dmc_ack,
	output logic                   pause_cpu
);
	import nes_bus_pkg::*;

	logic      dmc_state;       // DMC fetch armed
	logic [1:0] spr_state;      // Bit 0 requested, bit 1 transferring
	cpu_addr_t spr_addr;        // Page in high byte, n in low byte
	byte_t     last_val;
	logic [8:0] next_lo;        // Carry out ends the transfer
	logic      odd;
	logic      sprite_trigger;

	assign odd            = ce.odd_cycle;
	assign sprite_trigger = cpu_bus.write && cpu_bus.addr == OAM_DMA_ADDR;
	assign next_lo        = {1'b0, spr_addr[7:0]} + 9'd1;

	always_ff @(posedge clk) begin
		if (reset) begin
			dmc_state <= 1'b0;
			spr_state <= 2'b00;
		end else if (ce.cpu_ce) begin
			// DMC arms on an even read cycle, fires on the next even one
			if (!dmc_state && dmc_req && cpu_read && !odd)
				dmc_state <= 1'b1;
			if (dmc_state && !odd)
				dmc_state <= 1'b0;

			if (sprite_trigger)
				spr_state <= 2'b01;
			if (spr_state == 2'b01 && cpu_read && odd)
				spr_state <= 2'b11;             // Start on the odd read cycle
			if (spr_state[1] && !odd && dmc_state)
				spr_state <= 2'b01;             // DMC stole the slot, idle one cycle
			if (spr_state[1] && odd && next_lo[8])
				spr_state <= 2'b00;             // n = 255 written
		end
	end

	always_ff @(posedge clk) begin
		if (ce.cpu_ce) begin
			if (sprite_trigger)
				spr_addr <= {cpu_bus.data, 8'h00};
			else if (spr_state[1] && odd)
				spr_addr[7:0] <= next_lo[7:0];
			if (spr_state[1])
				last_val <= ram_data;  // Byte for the following $2004 write
		end
	end

	assign dmc_ack    = dmc_state && !odd;
	assign dma_active = dmc_ack || spr_state[1];
	assign pause_cpu  = spr_state[0] || dmc_req;

	// Even cycles read, odd cycles write to OAM
	assign dma_bus.addr  = dmc_ack ? dmc_addr : (odd ? OAM_DATA_ADDR : spr_addr);
	assign dma_bus.data  = last_val;
	assign dma_bus.read  = !odd;
	assign dma_bus.write = odd;

	dmc_ack_even: assert property (@(posedge clk) disable iff (reset)
		$rose(dmc_ack) |-> $past(ce.cpu_ce && odd))
		else $error("dmc_ack rose other than at the start of an even cycle");
	sprite_start_even: assert property (@(posedge clk) disable iff (reset)
		$rose(spr_state[1]) |-> !odd)
		else $error("Sprite transfer started on an odd cycle");

endmodule

/* source/clock_enables.sv */
// Master clock divider giving CPU/PPU enables and access slots; one instance drives the system
`timescale 1ns/100ps

module clock_enables #(
	parameter int div_cpu_n = nes_bus_pkg::DIV_CPU_DEFAULT,
	parameter int div_ppu_n = nes_bus_pkg::DIV_PPU_DEFAULT
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic [1:0]           sys_type,  // Bit 0 selects PAL
	output nes_bus_pkg::clk_en_t ce
);
	localparam int cpu_w = $clog2(div_cpu_n + 1);
	localparam int ppu_w = $clog2(div_ppu_n + 1);

	logic [cpu_w-1:0] div_cpu;
	logic [ppu_w-1:0] div_ppu;
	logic [1:0]       ppu_tick;    // PPU ticks since last cpu_ce
	logic [2:0]       tick_count;  // PAL cycle count, wraps at 5
	logic             pal;
	logic             odd_cycle;
	logic             cpu_ce;
	logic             ppu_ce;
	logic             stretch;
	logic             hold_cpu;

	assign cpu_ce   = div_cpu == cpu_w'(div_cpu_n);
	assign ppu_ce   = div_ppu == ppu_w'(div_ppu_n);
	assign stretch  = pal && tick_count == 3'd4;  // Fifth PAL cycle
	// One clock only, the end of PPU tick 0
	assign hold_cpu = stretch && ppu_tick == 2'd0 && ppu_ce;

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cpu    <= cpu_w'(1);
			div_ppu    <= ppu_w'(1);
			ppu_tick   <= 2'd0;
			tick_count <= 3'd0;
			odd_cycle  <= 1'b0;
			pal        <= sys_type[0];  // Static, taken only while in reset
		end else begin
			if (cpu_ce)
				div_cpu <= cpu_w'(1);
			else if (!hold_cpu)
				div_cpu <= div_cpu + 1'b1;
			div_ppu <= ppu_ce ? ppu_w'(1) : div_ppu + 1'b1;

			// Tick count restarts at the first PPU tick of each CPU cycle
			if (cpu_ce)
				ppu_tick <= 2'd0;
			else if (ppu_ce)
				ppu_tick <= ppu_tick + 1'b1;

			if (cpu_ce && pal)
				tick_count <= (tick_count == 3'd4) ? 3'd0 : tick_count + 1'b1;
			if (cpu_ce)
				odd_cycle <= !odd_cycle;
		end
	end

	assign ce.cpu_ce    = cpu_ce;
	assign ce.ppu_ce    = ppu_ce;
	assign ce.cart_pre  = ppu_tick == (stretch ? 2'd1 : 2'd0);  // Slots move one tick late
	assign ce.ppu_io    = ppu_tick == (stretch ? 2'd2 : 2'd1);
	assign ce.odd_cycle = odd_cycle;

	cpu_ce_single: assert property (@(posedge clk) disable iff (reset) cpu_ce |=> !cpu_ce)
		else $error("cpu_ce high on two clocks in a row");
	ppu_ce_single: assert property (@(posedge clk) disable iff (reset) ppu_ce |=> !ppu_ce)
		else $error("ppu_ce high on two clocks in a row");

endmodule

/* source/nes_bus_pkg.sv */
// Shared bus widths, register address map and struct types, imported by every RTL block
package nes_bus_pkg;

	// Bus widths
	localparam int CPU_ADDR_W = 16;
	localparam int MEM_ADDR_W = 22;  // Linear address into the shared memory
	localparam int DATA_W     = 8;

	typedef logic [CPU_ADDR_W-1:0] cpu_addr_t;
	typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
	typedef logic [DATA_W-1:0]     byte_t;

	// One bus cycle on the CPU side
	typedef struct packed {
		cpu_addr_t addr;
		byte_t     data;
		logic      read;
		logic      write;
	} cpu_bus_t;

	// One access to the shared memory
	typedef struct packed {
		mem_addr_t addr;
		byte_t     data;
		logic      read;
		logic      write;
	} mem_req_t;

	// Enables and slot strobes for the current master clock
	typedef struct packed {
		logic cpu_ce;
		logic ppu_ce;
		logic cart_pre;   // Program fetch slot
		logic ppu_io;     // PPU register access slot
		logic odd_cycle;  // 1 on odd CPU cycles
	} clk_en_t;

	typedef struct packed {
		logic       strobe;
		logic [1:0] clock;  // One per pad
	} joypad_t;

	// Register map
	localparam cpu_addr_t OAM_DMA_ADDR    = 16'h4014;
	localparam cpu_addr_t OAM_DATA_ADDR   = 16'h2004;
	localparam cpu_addr_t APU_STATUS_ADDR = 16'h4015;
	localparam cpu_addr_t JOY1_ADDR       = 16'h4016;
	localparam cpu_addr_t JOY2_ADDR       = 16'h4017;
	localparam cpu_addr_t PPU_LO          = 16'h2000;
	localparam cpu_addr_t PPU_HI          = 16'h4000;
	localparam cpu_addr_t APU_LO          = 16'h4000;
	localparam cpu_addr_t APU_HI          = 16'h4018;
	localparam cpu_addr_t OPEN_LO         = 16'h4018;  // Unmapped, reads float
	localparam cpu_addr_t OPEN_HI         = 16'h4100;

	// Master clocks per CPU and PPU tick
	localparam int DIV_CPU_DEFAULT = 12;
	localparam int DIV_PPU_DEFAULT = 4;

endpackage
